// File: Bender.yml
package:
  name: ooo_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isa_pkg.sv
      - hdl/core_pkg.sv
      - hdl/core_ifs.sv
      - hdl/inst_buffer.sv
      - hdl/rename_stage.sv
      - hdl/issue_execute.sv
      - hdl/reorder_buffer.sv
      - hdl/ooo_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/ooo_core_tb.sv

// File: hdl/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath width
`define DATA_W    32

// register counts, architectural and physical
`define NUM_AREG  32
`define NUM_PREG  64

// queue depths
`define ROB_DEPTH 16
// intake buffer depth, equal to the sender's starting credit
`define IB_DEPTH  4
// issue queue depth, equal to the rename stage's starting credit
`define IQ_DEPTH  4

`endif

// File: hdl/core_ifs.sv
`timescale 1ns/1ps
`include "core_consts.svh"

// renamed instructions, rename to issue, credit returned per issued entry
interface issue_if;
  logic               valid;
  isa_pkg::opcode_e   op;
  core_pkg::preg_t    prd;
  core_pkg::preg_t    prs1;
  core_pkg::preg_t    prs2;
  logic signed [15:0] imm;
  core_pkg::rob_idx_t rob_idx;
  logic               write;
  logic               credit;

  modport producer (
    output valid, op, prd, prs1, prs2, imm, rob_idx, write,
    input  credit
  );
  modport consumer (
    input  valid, op, prd, prs1, prs2, imm, rob_idx, write,
    output credit
  );
endinterface

// ROB allocation from the rename stage
interface dispatch_if;
  logic                         alloc;
  logic                         halt;
  logic                         illegal;
  logic                         write;
  logic [$clog2(`NUM_AREG)-1:0] rd;
  core_pkg::preg_t              prd;
  core_pkg::preg_t              old_prd;
  core_pkg::rob_idx_t           tail_idx;
  logic                         full;

  modport producer (
    output alloc, halt, illegal, write, rd, prd, old_prd,
    input  tail_idx, full
  );
  modport consumer (
    input  alloc, halt, illegal, write, rd, prd, old_prd,
    output tail_idx, full
  );
endinterface

// result broadcast, one cycle, no back-pressure
interface cdb_if;
  logic               valid;
  core_pkg::rob_idx_t rob_idx;
  core_pkg::preg_t    prd;
  core_pkg::data_t    value;

  modport producer (output valid, rob_idx, prd, value);
  modport consumer (input valid, rob_idx, value);
endinterface

// File: hdl/core_pkg.sv
`include "core_consts.svh"

package core_pkg;

  typedef logic [$clog2(`NUM_PREG)-1:0]  preg_t;
  typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;
  typedef logic [`DATA_W-1:0]            data_t;

  // one reorder buffer slot
  typedef struct packed {
    logic                         complete;
    logic                         halt;
    logic                         illegal;
    // set only for ALU ops with nonzero rd
    logic                         write;
    logic [$clog2(`NUM_AREG)-1:0] rd;
    preg_t                        new_prd;
    // previous mapping of rd, freed at retirement
    preg_t                        old_prd;
    data_t                        value;
  } rob_entry_t;

endpackage

// File: hdl/inst_buffer.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module inst_buffer (
  input  logic           clock,
  input  logic           rst,
  input  logic           in_valid,
  input  isa_pkg::inst_t in_inst,
  input  logic           take,
  output logic           out_valid,
  output isa_pkg::inst_t out_inst,
  output logic           credit
);

  localparam int PTR_W = $clog2(`IB_DEPTH);

  isa_pkg::inst_t   mem [`IB_DEPTH];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W:0]   count;

  // oldest entry is always presented
  assign out_valid = count != '0;
  assign out_inst  = mem[head];

  always_ff @(posedge clock) begin
    if (rst) begin
      head   <= '0;
      tail   <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (in_valid) begin
        tail <= tail + 1'b1;
      end
      if (take) begin
        head <= head + 1'b1;
      end
      count  <= count + in_valid - take;
      // one credit back per entry taken, a cycle later
      credit <= take;
    end
  end

  // sender holds credits, so a push never finds the buffer full
  always_ff @(posedge clock) begin
    if (in_valid) begin
      mem[tail] <= in_inst;
    end
  end

endmodule

// File: hdl/isa_pkg.sv
package isa_pkg;

  // opcode field, any code above OP_HALT is illegal
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_ADDI = 3'd2,
    OP_XOR  = 3'd3,
    OP_HALT = 3'd4
  } opcode_e;

  typedef enum logic [1:0] {
    NO_ERROR          = 2'd0,
    HALTED_ON_HALT    = 2'd1,
    HALTED_ON_ILLEGAL = 2'd2
  } error_e;

  // raw 34-bit instruction as it arrives at the core
  typedef struct packed {
    logic [2:0]         op;
    logic [4:0]         rd;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic signed [15:0] imm;
  } inst_t;

endpackage

// File: hdl/issue_execute.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module issue_execute (
  input  logic      clock,
  input  logic      rst,
  issue_if.consumer iq,
  cdb_if.producer   cdb
);

  localparam int PTR_W = $clog2(`IQ_DEPTH);

  typedef struct packed {
    isa_pkg::opcode_e   op;
    core_pkg::preg_t    prd;
    core_pkg::preg_t    prs1;
    core_pkg::preg_t    prs2;
    logic signed [15:0] imm;
    core_pkg::rob_idx_t rob_idx;
  } iq_entry_t;

  iq_entry_t            queue [`IQ_DEPTH];
  iq_entry_t            hd;
  logic [PTR_W-1:0]     q_head;
  logic [PTR_W-1:0]     q_tail;
  logic [PTR_W:0]       q_count;
  logic [`NUM_PREG-1:0] ready;
  core_pkg::data_t      prf [`NUM_PREG];
  logic                 src1_fwd;
  logic                 src2_fwd;
  logic                 src1_rdy;
  logic                 src2_rdy;
  logic                 do_issue;
  core_pkg::data_t      opa;
  core_pkg::data_t      opb;
  core_pkg::data_t      imm_ext;
  core_pkg::data_t      result;

  assign hd = queue[q_head];

  // bypass the result on the cdb, tag 0 is never a real producer
  assign src1_fwd = cdb.valid && cdb.prd == hd.prs1 && hd.prs1 != '0;
  assign src2_fwd = cdb.valid && cdb.prd == hd.prs2 && hd.prs2 != '0;
  assign src1_rdy = ready[hd.prs1] || src1_fwd;
  // ADDI has no second source
  assign src2_rdy = hd.op == isa_pkg::OP_ADDI || ready[hd.prs2] || src2_fwd;

  // in-order issue from the head only
  assign do_issue = q_count != '0 && src1_rdy && src2_rdy;

  assign opa     = src1_fwd ? cdb.value : prf[hd.prs1];
  assign opb     = src2_fwd ? cdb.value : prf[hd.prs2];
  assign imm_ext = {{(`DATA_W - 16){hd.imm[15]}}, hd.imm};

  always_comb begin
    case (hd.op)
      isa_pkg::OP_ADD:  result = opa + opb;
      isa_pkg::OP_SUB:  result = opa - opb;
      isa_pkg::OP_ADDI: result = opa + imm_ext;
      isa_pkg::OP_XOR:  result = opa ^ opb;
      default:          result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      q_head  <= '0;
      q_tail  <= '0;
      q_count <= '0;
    end else begin
      if (iq.valid) begin
        q_tail <= q_tail + 1'b1;
      end
      if (do_issue) begin
        q_head <= q_head + 1'b1;
      end
      q_count <= q_count + iq.valid - do_issue;
    end
  end

  always_ff @(posedge clock) begin
    if (iq.valid) begin
      queue[q_tail] <= '{op: iq.op, prd: iq.prd, prs1: iq.prs1, prs2: iq.prs2,
                         imm: iq.imm, rob_idx: iq.rob_idx};
    end
  end

  // writeback from the broadcast; a new producer clears its tag at enqueue
  always_ff @(posedge clock) begin
    if (rst) begin
      ready <= {{(`NUM_PREG - `NUM_AREG){1'b0}}, {`NUM_AREG{1'b1}}};
      for (int i = 0; i < `NUM_AREG; i++) begin
        prf[i] <= '0;
      end
    end else begin
      if (cdb.valid && cdb.prd != '0) begin
        prf[cdb.prd]   <= cdb.value;
        ready[cdb.prd] <= 1'b1;
      end
      if (iq.valid && iq.write) begin
        ready[iq.prd] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      cdb.valid <= 1'b0;
      iq.credit <= 1'b0;
    end else begin
      cdb.valid <= do_issue;
      iq.credit <= do_issue;
    end
  end

  always_ff @(posedge clock) begin
    if (do_issue) begin
      cdb.rob_idx <= hd.rob_idx;
      cdb.prd     <= hd.prd;
      cdb.value   <= result;
    end
  end

endmodule

// File: hdl/ooo_core.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module ooo_core (
  input  logic                         clock,
  input  logic                         rst,
  input  logic                         inst_valid,
  input  logic [2:0]                   inst_op,
  input  logic [4:0]                   inst_rd,
  input  logic [4:0]                   inst_rs1,
  input  logic [4:0]                   inst_rs2,
  input  logic [15:0]                  inst_imm,
  output logic                         inst_credit,
  output logic                         commit_en,
  output logic                         commit_wr_en,
  output logic [$clog2(`NUM_AREG)-1:0] commit_wr_idx,
  output logic [`DATA_W-1:0]           commit_wr_data,
  output logic                         stop_cycle,
  output isa_pkg::error_e              error_status
);

  isa_pkg::inst_t  in_inst;
  isa_pkg::inst_t  buf_inst;
  logic            buf_valid;
  logic            take;
  logic            free_en;
  core_pkg::preg_t free_tag;

  issue_if    iq_bus ();
  dispatch_if disp_bus ();
  cdb_if      cdb_bus ();

  assign in_inst = '{op: inst_op, rd: inst_rd, rs1: inst_rs1, rs2: inst_rs2, imm: inst_imm};

  inst_buffer inst_buffer_0 (
    .clock     (clock),
    .rst       (rst),
    .in_valid  (inst_valid),
    .in_inst   (in_inst),
    .take      (take),
    .out_valid (buf_valid),
    .out_inst  (buf_inst),
    .credit    (inst_credit)
  );

  rename_stage rename_stage_0 (
    .clock    (clock),
    .rst      (rst),
    .in_valid (buf_valid),
    .in_inst  (buf_inst),
    .take     (take),
    .free_en  (free_en),
    .free_tag (free_tag),
    .disp     (disp_bus.producer),
    .iq       (iq_bus.producer)
  );

  issue_execute issue_execute_0 (
    .clock (clock),
    .rst   (rst),
    .iq    (iq_bus.consumer),
    .cdb   (cdb_bus.producer)
  );

  reorder_buffer reorder_buffer_0 (
    .clock          (clock),
    .rst            (rst),
    .disp           (disp_bus.consumer),
    .cdb            (cdb_bus.consumer),
    .free_en        (free_en),
    .free_tag       (free_tag),
    .commit_en      (commit_en),
    .commit_wr_en   (commit_wr_en),
    .commit_wr_idx  (commit_wr_idx),
    .commit_wr_data (commit_wr_data),
    .stop_cycle     (stop_cycle),
    .error_status   (error_status)
  );

endmodule

// File: hdl/rename_stage.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module rename_stage (
  input  logic            clock,
  input  logic            rst,
  input  logic            in_valid,
  input  isa_pkg::inst_t  in_inst,
  output logic            take,
  input  logic            free_en,
  input  core_pkg::preg_t free_tag,
  dispatch_if.producer    disp,
  issue_if.producer       iq
);

  localparam int FL_DEPTH = `NUM_PREG - `NUM_AREG;
  localparam int FL_PTR_W = $clog2(FL_DEPTH);
  localparam int CRED_W   = $clog2(`IQ_DEPTH + 1);

  isa_pkg::opcode_e    op;
  logic                illegal;
  logic                halt;
  logic                to_issue;
  logic                write;
  logic                pop_tag;
  logic                send_iq;
  core_pkg::preg_t     new_tag;
  core_pkg::rob_idx_t  next_rob_idx;
  core_pkg::preg_t     map_table [`NUM_AREG];
  core_pkg::preg_t     fl_mem [FL_DEPTH];
  logic [FL_PTR_W-1:0] fl_head;
  logic [FL_PTR_W-1:0] fl_tail;
  logic [FL_PTR_W:0]   fl_count;
  logic [CRED_W-1:0]   credits;

  // decode
  assign op       = isa_pkg::opcode_e'(in_inst.op);
  assign illegal  = in_inst.op > isa_pkg::OP_HALT;
  assign halt     = !illegal && op == isa_pkg::OP_HALT;
  assign to_issue = !illegal && !halt;
  // r0 writes are executed but never renamed
  assign write    = to_issue && in_inst.rd != '0;

  // stall on full ROB, no issue credit, or empty free list
  assign take = in_valid && !disp.full
             && !(to_issue && credits == '0)
             && !(write && fl_count == '0);

  assign pop_tag = take && write;
  assign send_iq = take && to_issue;
  assign new_tag = write ? fl_mem[fl_head] : '0;

  // slot the ROB will use, counting the allocation still in flight
  assign next_rob_idx = disp.tail_idx + core_pkg::rob_idx_t'(disp.alloc);

  // free list, refilled from retirement
  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < FL_DEPTH; i++) begin
        fl_mem[i] <= core_pkg::preg_t'(`NUM_AREG + i);
      end
      fl_head  <= '0;
      fl_tail  <= '0;
      fl_count <= (FL_PTR_W + 1)'(FL_DEPTH);
    end else begin
      if (free_en) begin
        fl_mem[fl_tail] <= free_tag;
        fl_tail         <= fl_tail + 1'b1;
      end
      if (pop_tag) begin
        fl_head <= fl_head + 1'b1;
      end
      fl_count <= fl_count + free_en - pop_tag;
    end
  end

  // map table starts as identity, and the issue credit counter
  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < `NUM_AREG; i++) begin
        map_table[i] <= core_pkg::preg_t'(i);
      end
      credits <= CRED_W'(`IQ_DEPTH);
    end else begin
      if (pop_tag) begin
        map_table[in_inst.rd] <= new_tag;
      end
      credits <= credits + iq.credit - send_iq;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      disp.alloc <= 1'b0;
      iq.valid   <= 1'b0;
    end else begin
      disp.alloc <= take;
      iq.valid   <= send_iq;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      disp.halt    <= halt;
      disp.illegal <= illegal;
      disp.write   <= write;
      disp.rd      <= in_inst.rd;
      disp.prd     <= new_tag;
      disp.old_prd <= map_table[in_inst.rd];
      iq.op        <= op;
      iq.prd       <= new_tag;
      iq.prs1      <= map_table[in_inst.rs1];
      iq.prs2      <= map_table[in_inst.rs2];
      iq.imm       <= in_inst.imm;
      iq.rob_idx   <= next_rob_idx;
      iq.write     <= write;
    end
  end

endmodule

// File: hdl/reorder_buffer.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module reorder_buffer (
  input  logic                         clock,
  input  logic                         rst,
  dispatch_if.consumer                 disp,
  cdb_if.consumer                      cdb,
  output logic                         free_en,
  output core_pkg::preg_t              free_tag,
  output logic                         commit_en,
  output logic                         commit_wr_en,
  output logic [$clog2(`NUM_AREG)-1:0] commit_wr_idx,
  output core_pkg::data_t              commit_wr_data,
  output logic                         stop_cycle,
  output isa_pkg::error_e              error_status
);

  core_pkg::rob_entry_t          rob [`ROB_DEPTH];
  core_pkg::rob_entry_t          hd;
  core_pkg::rob_idx_t            head;
  core_pkg::rob_idx_t            tail;
  logic [$clog2(`ROB_DEPTH):0]   count;
  logic                          head_done;
  logic                          retire;
  logic                          stop;

  assign hd        = rob[head];
  assign head_done = !stop_cycle && count != '0 && hd.complete;
  assign retire    = head_done && !hd.halt && !hd.illegal;
  assign stop      = head_done && (hd.halt || hd.illegal);

  assign disp.tail_idx = tail;
  // the allocation already in flight counts as taken
  assign disp.full     = count + disp.alloc >= `ROB_DEPTH;

  always_ff @(posedge clock) begin
    if (disp.alloc) begin
      // halt and illegal entries never issue, so they start complete
      rob[tail] <= '{complete: disp.halt || disp.illegal, halt: disp.halt,
                     illegal: disp.illegal, write: disp.write, rd: disp.rd,
                     new_prd: disp.prd, old_prd: disp.old_prd, value: '0};
    end
    if (cdb.valid) begin
      rob[cdb.rob_idx].complete <= 1'b1;
      rob[cdb.rob_idx].value    <= cdb.value;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (disp.alloc) begin
        tail <= tail + 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
      count <= count + disp.alloc - retire;
    end
  end

  // commit and stop status, one cycle after the head retires or halts
  always_ff @(posedge clock) begin
    if (rst) begin
      commit_en    <= 1'b0;
      commit_wr_en <= 1'b0;
      free_en      <= 1'b0;
      stop_cycle   <= 1'b0;
      error_status <= isa_pkg::NO_ERROR;
    end else begin
      commit_en    <= retire;
      commit_wr_en <= retire && hd.write;
      free_en      <= retire && hd.write;
      if (stop) begin
        stop_cycle   <= 1'b1;
        error_status <= hd.halt ? isa_pkg::HALTED_ON_HALT : isa_pkg::HALTED_ON_ILLEGAL;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (retire) begin
      commit_wr_idx  <= hd.rd;
      commit_wr_data <= hd.value;
      free_tag       <= hd.old_prd;
    end
  end

endmodule

// File: tb/ooo_core_tb.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module ooo_core_tb;

  // one expected commit, or the point where retirement has to stop
  typedef struct packed {
    logic        stop;
    logic        wr_en;
    logic [4:0]  idx;
    logic [31:0] data;
  } exp_t;

  logic            clock;
  logic            rst;
  logic            inst_valid;
  logic [2:0]      inst_op;
  logic [4:0]      inst_rd;
  logic [4:0]      inst_rs1;
  logic [4:0]      inst_rs2;
  logic [15:0]     inst_imm;
  logic            inst_credit;
  logic            commit_en;
  logic            commit_wr_en;
  logic [4:0]      commit_wr_idx;
  logic [31:0]     commit_wr_data;
  logic            stop_cycle;
  isa_pkg::error_e error_status;

  logic [31:0] ref_regs [32];
  exp_t        exp_q [$];
  logic        model_stopped;
  int          credits;
  int          sent;
  int          returned;

  ooo_core dut (
    .clock          (clock),
    .rst            (rst),
    .inst_valid     (inst_valid),
    .inst_op        (inst_op),
    .inst_rd        (inst_rd),
    .inst_rs1       (inst_rs1),
    .inst_rs2       (inst_rs2),
    .inst_imm       (inst_imm),
    .inst_credit    (inst_credit),
    .commit_en      (commit_en),
    .commit_wr_en   (commit_wr_en),
    .commit_wr_idx  (commit_wr_idx),
    .commit_wr_data (commit_wr_data),
    .stop_cycle     (stop_cycle),
    .error_status   (error_status)
  );

  always #5 clock = ~clock;

  task automatic fail_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("MISMATCH time=%0t signal=%s expected=0x%0h actual=0x%0h",
             $time, name, expected, actual);
    fail_run();
  endtask

  // sequential execution on the architectural registers
  function automatic void model_step(input logic [2:0] op, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [4:0] rs2,
                                     input logic [15:0] imm);
    exp_t        want;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    if (model_stopped) begin
      return;
    end
    want = '0;
    if (op >= isa_pkg::OP_HALT) begin
      want.stop = 1'b1;
      exp_q.push_back(want);
      model_stopped = 1'b1;
      return;
    end
    a = ref_regs[rs1];
    b = ref_regs[rs2];
    case (op)
      isa_pkg::OP_ADD:  res = a + b;
      isa_pkg::OP_SUB:  res = a - b;
      isa_pkg::OP_ADDI: res = a + {{16{imm[15]}}, imm};
      default:          res = a ^ b;
    endcase
    if (rd != 5'd0) begin
      ref_regs[rd] = res;
    end
    want.wr_en = rd != 5'd0;
    want.idx   = rd;
    want.data  = res;
    exp_q.push_back(want);
  endfunction

  task automatic apply_reset();
    rst        = 1'b1;
    inst_valid = 1'b0;
    credits       = `IB_DEPTH;
    sent          = 0;
    returned      = 0;
    model_stopped = 1'b0;
    exp_q.delete();
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    repeat (2) @(posedge clock);
    #1;
    rst = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  // send one instruction once a credit is held
  task automatic send_inst(input logic [2:0] op, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [15:0] imm);
    int waited;
    waited = 0;
    inst_valid = 1'b0;
    while (credits == 0) begin
      @(posedge clock);
      #1;
      waited++;
      assert (waited < 200) else begin
        $display("timeout: no intake credit came back within 200 cycles");
        fail_run();
      end
    end
    inst_valid = 1'b1;
    inst_op    = op;
    inst_rd    = rd;
    inst_rs1   = rs1;
    inst_rs2   = rs2;
    inst_imm   = imm;
    credits--;
    sent++;
    model_step(op, rd, rs1, rs2, imm);
    @(posedge clock);
    #1;
    inst_valid = 1'b0;
  endtask

  task automatic send_random_alu(input int max_reg);
    logic [2:0] op;
    op = 3'($urandom_range(0, 3));
    send_inst(op, 5'($urandom_range(0, max_reg)), 5'($urandom_range(0, max_reg)),
              5'($urandom_range(0, max_reg)), 16'($urandom()));
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(posedge clock);
      #1;
      n++;
      assert (n < 2000) else begin
        $display("timeout: %0d commits still missing after 2000 cycles", exp_q.size());
        fail_run();
      end
    end
  endtask

  task automatic wait_stop();
    int n;
    n = 0;
    while (stop_cycle !== 1'b1) begin
      @(posedge clock);
      #1;
      n++;
      assert (n < 500) else begin
        $display("timeout: stop_cycle did not rise within 500 cycles");
        fail_run();
      end
    end
  endtask

  // everything before the stopping entry has retired and nothing after it may
  task automatic check_stop(input isa_pkg::error_e status);
    wait_stop();
    assert (exp_q.size() == 1 && exp_q[0].stop) else begin
      $display("retirement stopped with %0d expected entries outstanding", exp_q.size());
      fail_run();
    end
    exp_q.delete();
    assert (error_status === status) else report_mismatch("error_status", status, error_status);
    repeat (50) begin
      @(posedge clock);
      #1;
      assert (stop_cycle === 1'b1) else report_mismatch("stop_cycle", 1, stop_cycle);
    end
  endtask

  // one sender credit back per returned pulse
  always @(negedge clock) begin
    if (!rst && inst_credit) begin
      credits++;
      returned++;
      assert (credits <= `IB_DEPTH) else begin
        $display("sender credit count rose to %0d, above the intake depth", credits);
        fail_run();
      end
    end
  end

  // commit checker
  always @(negedge clock) begin
    exp_t want;
    if (!rst && commit_en) begin
      assert (exp_q.size() != 0 && !exp_q[0].stop) else begin
        $display("commit_en raised at %0t with no instruction left to retire", $time);
        fail_run();
      end
      want = exp_q.pop_front();
      assert (commit_wr_en === want.wr_en)
        else report_mismatch("commit_wr_en", want.wr_en, commit_wr_en);
      assert (commit_wr_idx === want.idx)
        else report_mismatch("commit_wr_idx", want.idx, commit_wr_idx);
      assert (commit_wr_data === want.data)
        else report_mismatch("commit_wr_data", want.data, commit_wr_data);
    end
  end

  initial begin
    logic [4:0] prev;
    logic [4:0] rd;
    int         burst_len;
    clock      = 1'b0;
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst_op    = '0;
    inst_rd    = '0;
    inst_rs1   = '0;
    inst_rs2   = '0;
    inst_imm   = '0;
    void'($urandom(14));
    apply_reset();

    // outputs one cycle after reset release
    idle_cycles(1);
    assert (commit_en === 1'b0) else report_mismatch("commit_en", 0, commit_en);
    assert (commit_wr_en === 1'b0) else report_mismatch("commit_wr_en", 0, commit_wr_en);
    assert (inst_credit === 1'b0) else report_mismatch("inst_credit", 0, inst_credit);
    assert (stop_cycle === 1'b0) else report_mismatch("stop_cycle", 0, stop_cycle);
    assert (error_status === isa_pkg::NO_ERROR)
      else report_mismatch("error_status", isa_pkg::NO_ERROR, error_status);

    // few registers so tags recycle through the free list many times
    repeat (300) send_random_alu(7);
    wait_drain();

    // each instruction reads the previous destination
    prev = 5'd1;
    for (int i = 0; i < 40; i++) begin
      rd = 5'(1 + (i % 31));
      send_inst(3'($urandom_range(0, 3)), rd, prev, prev, 16'($urandom()));
      prev = rd;
    end
    wait_drain();

    // back-to-back bursts separated by idle gaps
    for (int b = 0; b < 5; b++) begin
      burst_len = 0;
      while (credits != 0 && burst_len < 16) begin
        send_random_alu(15);
        burst_len++;
      end
      idle_cycles(20);
    end
    wait_drain();
    idle_cycles(2);
    assert (returned == sent) else report_mismatch("credits returned", sent, returned);

    // halt with younger instructions behind it
    repeat (10) send_random_alu(7);
    send_inst(isa_pkg::OP_HALT, 5'd0, 5'd0, 5'd0, 16'd0);
    repeat (3) send_random_alu(7);
    check_stop(isa_pkg::HALTED_ON_HALT);

    // unknown opcode mid-stream
    apply_reset();
    repeat (12) send_random_alu(7);
    send_inst(3'd6, 5'd3, 5'd1, 5'd2, 16'd0);
    repeat (3) send_random_alu(7);
    check_stop(isa_pkg::HALTED_ON_ILLEGAL);

    $display("All checks passed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/core_ifs.sv
hdl/inst_buffer.sv
hdl/rename_stage.sv
hdl/issue_execute.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
tb/ooo_core_tb.sv
